// ==== mips_pkg.sv ====
/* mips32 subset shared types.
   opcode and funct codes, control mux encodings and the decoder control word. */
package mips_pkg;

	// primary opcode field, instr[31:26].
	typedef enum logic [5:0] {
		op_r_type = 6'b000000,
		op_j      = 6'b000010,
		op_jal    = 6'b000011,
		op_beq    = 6'b000100,
		op_bne    = 6'b000101,
		op_addi   = 6'b001000,
		op_lw     = 6'b100011,
		op_sw     = 6'b101011
	} opcode_e;

	// r-type function field, instr[5:0].
	typedef enum logic [5:0] {
		fn_jr  = 6'b001000,
		fn_add = 6'b100000,
		fn_sub = 6'b100010,
		fn_and = 6'b100100,
		fn_or  = 6'b100101,
		fn_slt = 6'b101010
	} funct_e;

	// alu class picked by the decoder.
	typedef enum logic [1:0] {
		class_mem     = 2'b00,
		class_branch  = 2'b01,
		class_arith   = 2'b10,
		class_invalid = 2'b11
	} alu_class_e;

	typedef enum logic [2:0] {
		alu_and = 3'b000,
		alu_or  = 3'b001,
		alu_add = 3'b010,
		alu_sub = 3'b110,
		alu_slt = 3'b111
	} alu_fn_e;

	// destination register select.
	typedef enum logic [1:0] {
		dst_rt      = 2'b00,
		dst_rd      = 2'b01,
		dst_ra      = 2'b10,
		dst_invalid = 2'b11
	} reg_dst_e;

	// write-back source select.
	typedef enum logic [1:0] {
		wb_alu      = 2'b00,
		wb_mem      = 2'b01,
		wb_pc_plus4 = 2'b10,
		wb_invalid  = 2'b11
	} mem_to_reg_e;

	// msb enables the branch, lsb set means equal.
	typedef enum logic [1:0] {
		br_off       = 2'b00,
		br_not_equal = 2'b10,
		br_equal     = 2'b11
	} branch_e;

	typedef enum logic [1:0] {
		jmp_none     = 2'b00,
		jmp_target   = 2'b01,
		jmp_register = 2'b10,
		jmp_invalid  = 2'b11
	} jump_e;

	typedef struct packed {
		alu_class_e  alu_class;
		mem_to_reg_e mem_to_reg;
		logic        mem_write;
		logic        mem_read;
		branch_e     branch;
		logic        alu_src;
		reg_dst_e    reg_dst;
		logic        reg_write;
		jump_e       jump;
	} ctrl_t;

endpackage

// ==== main_decoder.sv ====
/* main control unit.
   decodes opcode and funct into the control word and flags illegal opcodes. */
`timescale 1ns/1ps

module main_decoder import mips_pkg::*; (
	input  opcode_e opcode,
	input  funct_e  funct,
	output ctrl_t   ctrl,
	output logic    err_illegal_opcode
);

	logic is_jr;

	// jr shares the r-type opcode.
	assign is_jr = (funct == fn_jr);

	always_comb begin
		err_illegal_opcode = 1'b0;
		case (opcode)
			op_r_type: begin
				ctrl = '{alu_class: class_arith, alu_src: 1'b0, mem_to_reg: wb_alu,
					mem_read: 1'b0, mem_write: 1'b0, reg_dst: dst_rd,
					reg_write: !is_jr, branch: br_off,
					jump: is_jr ? jmp_register : jmp_none};
			end
			op_lw: begin
				ctrl = '{alu_class: class_mem, alu_src: 1'b1, mem_to_reg: wb_mem,
					mem_read: 1'b1, mem_write: 1'b0, reg_dst: dst_rt,
					reg_write: 1'b1, branch: br_off, jump: jmp_none};
			end
			op_sw: begin
				ctrl = '{alu_class: class_mem, alu_src: 1'b1, mem_to_reg: wb_invalid,
					mem_read: 1'b0, mem_write: 1'b1, reg_dst: dst_invalid,
					reg_write: 1'b0, branch: br_off, jump: jmp_none};
			end
			op_beq: begin
				ctrl = '{alu_class: class_branch, alu_src: 1'b0, mem_to_reg: wb_invalid,
					mem_read: 1'b0, mem_write: 1'b0, reg_dst: dst_invalid,
					reg_write: 1'b0, branch: br_equal, jump: jmp_none};
			end
			op_bne: begin
				ctrl = '{alu_class: class_branch, alu_src: 1'b0, mem_to_reg: wb_invalid,
					mem_read: 1'b0, mem_write: 1'b0, reg_dst: dst_invalid,
					reg_write: 1'b0, branch: br_not_equal, jump: jmp_none};
			end
			op_addi: begin
				// immediate add reuses the address adder.
				ctrl = '{alu_class: class_mem, alu_src: 1'b1, mem_to_reg: wb_alu,
					mem_read: 1'b0, mem_write: 1'b0, reg_dst: dst_rt,
					reg_write: 1'b1, branch: br_off, jump: jmp_none};
			end
			op_j: begin
				ctrl = '{alu_class: class_invalid, alu_src: 1'b0, mem_to_reg: wb_invalid,
					mem_read: 1'b0, mem_write: 1'b0, reg_dst: dst_invalid,
					reg_write: 1'b0, branch: br_off, jump: jmp_target};
			end
			op_jal: begin
				// link address goes to register 31.
				ctrl = '{alu_class: class_invalid, alu_src: 1'b0, mem_to_reg: wb_pc_plus4,
					mem_read: 1'b0, mem_write: 1'b0, reg_dst: dst_ra,
					reg_write: 1'b1, branch: br_off, jump: jmp_target};
			end
			default: begin
				// no-op with the pc stepping by four.
				ctrl = '{alu_class: class_invalid, alu_src: 1'b0, mem_to_reg: wb_invalid,
					mem_read: 1'b0, mem_write: 1'b0, reg_dst: dst_invalid,
					reg_write: 1'b0, branch: br_off, jump: jmp_none};
				err_illegal_opcode = 1'b1;
			end
		endcase
	end

endmodule

// ==== alu_control.sv ====
/* alu operation select.
   maps the decoder's alu class and the funct field to an alu function. */
`timescale 1ns/1ps

module alu_control import mips_pkg::*; (
	input  alu_class_e alu_class,
	input  funct_e     funct,
	output alu_fn_e    alu_fn
);

	always_comb begin
		case (alu_class)
			class_mem:    alu_fn = alu_add;
			// compare for beq and bne.
			class_branch: alu_fn = alu_sub;
			class_arith: begin
				case (funct)
					fn_sub:  alu_fn = alu_sub;
					fn_and:  alu_fn = alu_and;
					fn_or:   alu_fn = alu_or;
					fn_slt:  alu_fn = alu_slt;
					// add, jr and unknown functs.
					default: alu_fn = alu_add;
				endcase
			end
			default:      alu_fn = alu_add;
		endcase
	end

endmodule

// ==== alu.sv ====
/* 32-bit alu.
   add, subtract, and, or and signed set-less-than, with a zero flag. */
`timescale 1ns/1ps

module alu import mips_pkg::*; (
	input  logic [31:0] a,
	input  logic [31:0] b,
	input  alu_fn_e     alu_fn,
	output logic [31:0] result,
	output logic        zero
);

	always_comb begin
		case (alu_fn)
			alu_and: result = a & b;
			alu_or:  result = a | b;
			alu_sub: result = a - b;
			// signed compare, result is 0 or 1.
			alu_slt: result = {31'd0, $signed(a) < $signed(b)};
			default: result = a + b;
		endcase
	end

	// drives the branch decision.
	assign zero = (result == 32'd0);

endmodule

// ==== reg_file.sv ====
/* general register file.
   32 registers, two combinational read ports, one write port, r0 reads zero. */
`timescale 1ns/1ps

module reg_file (
	input  logic        clk,
	input  logic        arst_n,
	input  logic [4:0]  rs_addr,
	input  logic [4:0]  rt_addr,
	input  logic [4:0]  wr_addr,
	input  logic        wr_en,
	input  logic [31:0] wr_data,
	output logic [31:0] rs_data,
	output logic [31:0] rt_data
);

	// r0 has no storage.
	logic [31:0] regs [1:31];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= 32'd0;
			end
		end else if (wr_en && wr_addr != 5'd0) begin
			regs[wr_addr] <= wr_data;
		end
	end

	assign rs_data = (rs_addr == 5'd0) ? 32'd0 : regs[rs_addr];
	assign rt_data = (rt_addr == 5'd0) ? 32'd0 : regs[rt_addr];

endmodule

// ==== pc_unit.sv ====
/* program counter.
   holds the pc and picks the next one for sequential flow, branches and jumps. */
`timescale 1ns/1ps

module pc_unit import mips_pkg::*; (
	input  logic        clk,
	input  logic        arst_n,
	input  branch_e     branch,
	input  jump_e       jump,
	input  logic        zero,
	input  logic [15:0] imm,
	input  logic [25:0] target,
	input  logic [31:0] rs_data,
	output logic [31:0] pc,
	output logic [31:0] pc_plus4
);

	logic [31:0] pc_next;
	logic [31:0] imm_ext;
	logic [31:0] branch_target;
	logic        taken;

	assign pc_plus4 = pc + 32'd4;
	assign imm_ext = {{16{imm[15]}}, imm};
	// word offset relative to the next instruction.
	assign branch_target = pc_plus4 + {imm_ext[29:0], 2'b00};

	assign taken = (branch == br_equal && zero) || (branch == br_not_equal && !zero);

	always_comb begin
		if (jump == jmp_register) begin
			pc_next = rs_data;
		end else if (jump == jmp_target) begin
			// stays in the current 256 MB region.
			pc_next = {pc_plus4[31:28], target, 2'b00};
		end else if (taken) begin
			pc_next = branch_target;
		end else begin
			pc_next = pc_plus4;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pc <= 32'd0;
		end else begin
			pc <= pc_next;
		end
	end

endmodule

// ==== mips_core.sv ====
/* single-cycle mips32 subset core.
   decoder, alu path, register file and pc unit around external memory ports. */
`timescale 1ns/1ps

module mips_core import mips_pkg::*; (
	input  logic        clk,
	input  logic        arst_n,
	output logic [31:0] imem_addr,
	input  logic [31:0] instr,
	output logic [31:0] dmem_addr,
	output logic [31:0] dmem_wdata,
	output logic        dmem_we,
	output logic        dmem_re,
	input  logic [31:0] dmem_rdata,
	output logic        err_illegal_opcode
);

	ctrl_t       ctrl;
	alu_fn_e     alu_fn;
	logic [4:0]  rs;
	logic [4:0]  rt;
	logic [4:0]  rd;
	logic [15:0] imm;
	logic [31:0] imm_ext;
	logic [31:0] rs_data;
	logic [31:0] rt_data;
	logic [31:0] alu_b;
	logic [31:0] alu_result;
	logic        alu_zero;
	logic [4:0]  wr_addr;
	logic [31:0] wr_data;
	logic [31:0] pc;
	logic [31:0] pc_plus4;

	// instruction fields.
	assign rs = instr[25:21];
	assign rt = instr[20:16];
	assign rd = instr[15:11];
	assign imm = instr[15:0];
	assign imm_ext = {{16{imm[15]}}, imm};

	main_decoder u_decoder (
		.opcode             (opcode_e'(instr[31:26])),
		.funct              (funct_e'(instr[5:0])),
		.ctrl               (ctrl),
		.err_illegal_opcode (err_illegal_opcode)
	);

	alu_control u_alu_control (
		.alu_class (ctrl.alu_class),
		.funct     (funct_e'(instr[5:0])),
		.alu_fn    (alu_fn)
	);

	// second operand is rt or the immediate.
	assign alu_b = ctrl.alu_src ? imm_ext : rt_data;

	alu u_alu (
		.a      (rs_data),
		.b      (alu_b),
		.alu_fn (alu_fn),
		.result (alu_result),
		.zero   (alu_zero)
	);

	always_comb begin
		case (ctrl.reg_dst)
			dst_rt:  wr_addr = rt;
			dst_rd:  wr_addr = rd;
			dst_ra:  wr_addr = 5'd31;
			default: wr_addr = 5'd0;
		endcase
	end

	always_comb begin
		case (ctrl.mem_to_reg)
			wb_mem:      wr_data = dmem_rdata;
			wb_pc_plus4: wr_data = pc_plus4;
			default:     wr_data = alu_result;
		endcase
	end

	reg_file u_reg_file (
		.clk     (clk),
		.arst_n  (arst_n),
		.rs_addr (rs),
		.rt_addr (rt),
		.wr_addr (wr_addr),
		.wr_en   (ctrl.reg_write),
		.wr_data (wr_data),
		.rs_data (rs_data),
		.rt_data (rt_data)
	);

	pc_unit u_pc_unit (
		.clk      (clk),
		.arst_n   (arst_n),
		.branch   (ctrl.branch),
		.jump     (ctrl.jump),
		.zero     (alu_zero),
		.imm      (imm),
		.target   (instr[25:0]),
		.rs_data  (rs_data),
		.pc       (pc),
		.pc_plus4 (pc_plus4)
	);

	assign imem_addr = pc;

	// data memory port.
	assign dmem_addr = alu_result;
	assign dmem_wdata = rt_data;
	assign dmem_we = ctrl.mem_write;
	assign dmem_re = ctrl.mem_read;

endmodule

// ==== mips_checker.sv ====
/* reference model for the mips core.
   steps its own registers, memory and pc and compares the core's ports every cycle. */
`timescale 1ns/1ps

module mips_checker (
	input  logic        clk,
	input  logic        arst_n,
	input  logic [31:0] imem [256],
	input  logic [31:0] data_init [256],
	input  logic [31:0] imem_addr,
	input  logic [31:0] dmem_addr,
	input  logic [31:0] dmem_wdata,
	input  logic        dmem_we,
	input  logic        dmem_re,
	input  logic        err_illegal_opcode,
	output int          err_count
);

	// standard mips32 encodings.
	localparam logic [5:0] opc_special = 6'h00;
	localparam logic [5:0] opc_j = 6'h02;
	localparam logic [5:0] opc_jal = 6'h03;
	localparam logic [5:0] opc_beq = 6'h04;
	localparam logic [5:0] opc_bne = 6'h05;
	localparam logic [5:0] opc_addi = 6'h08;
	localparam logic [5:0] opc_lw = 6'h23;
	localparam logic [5:0] opc_sw = 6'h2b;
	localparam logic [5:0] fnc_jr = 6'h08;

	logic [31:0] regs [32];
	logic [31:0] mem [256];
	logic [31:0] pc;

	task automatic flag_mismatch(input string what, input logic [31:0] exp,
			input logic [31:0] act);
		$display("FAIL @%0t: %s expected %h, got %h", $time, what, exp, act);
		err_count++;
	endtask

	// unknown functs behave as add.
	function automatic logic [31:0] r_result(input logic [5:0] fn, input logic [31:0] a,
			input logic [31:0] b);
		case (fn)
			6'h22: return a - b;
			6'h24: return a & b;
			6'h25: return a | b;
			6'h2a: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			default: return a + b;
		endcase
	endfunction

	task automatic step_model();
		logic [31:0] ins;
		logic [31:0] rs_v;
		logic [31:0] rt_v;
		logic [31:0] simm;
		logic [31:0] pc4;
		logic [31:0] next_pc;
		logic [31:0] ea;
		logic        store;
		logic        load;
		logic        illegal;
		logic [4:0]  dst;
		logic [31:0] wval;
		ins = imem[pc[9:2]];
		rs_v = regs[ins[25:21]];
		rt_v = regs[ins[20:16]];
		simm = {{16{ins[15]}}, ins[15:0]};
		pc4 = pc + 32'd4;
		next_pc = pc4;
		ea = rs_v + simm;
		store = 1'b0;
		load = 1'b0;
		illegal = 1'b0;
		dst = 5'd0;
		wval = 32'd0;
		case (ins[31:26])
			opc_special: begin
				if (ins[5:0] == fnc_jr) begin
					next_pc = rs_v;
				end else begin
					dst = ins[15:11];
					wval = r_result(ins[5:0], rs_v, rt_v);
				end
			end
			opc_lw: begin
				load = 1'b1;
				dst = ins[20:16];
				wval = mem[ea[9:2]];
			end
			opc_sw: store = 1'b1;
			opc_beq: next_pc = (rs_v == rt_v) ? pc4 + {simm[29:0], 2'b00} : pc4;
			opc_bne: next_pc = (rs_v != rt_v) ? pc4 + {simm[29:0], 2'b00} : pc4;
			opc_addi: begin
				dst = ins[20:16];
				wval = ea;
			end
			opc_j: next_pc = {pc4[31:28], ins[25:0], 2'b00};
			opc_jal: begin
				dst = 5'd31;
				wval = pc4;
				next_pc = {pc4[31:28], ins[25:0], 2'b00};
			end
			default: illegal = 1'b1;
		endcase
		if (imem_addr !== pc)
			flag_mismatch("imem_addr", pc, imem_addr);
		if (err_illegal_opcode !== illegal)
			flag_mismatch("err_illegal_opcode", 32'(illegal), 32'(err_illegal_opcode));
		if (dmem_we !== store)
			flag_mismatch("dmem_we", 32'(store), 32'(dmem_we));
		if (dmem_re !== load)
			flag_mismatch("dmem_re", 32'(load), 32'(dmem_re));
		if (store && dmem_we) begin
			if (dmem_addr !== ea)
				flag_mismatch("dmem_addr", ea, dmem_addr);
			if (dmem_wdata !== rt_v)
				flag_mismatch("dmem_wdata", rt_v, dmem_wdata);
		end
		// r0 never changes.
		if (dst != 5'd0)
			regs[dst] = wval;
		if (store)
			mem[ea[9:2]] = rt_v;
		pc = next_pc;
	endtask

	// sample just after the falling edge, when the core has settled.
	always @(negedge clk) begin
		#1;
		if (!arst_n) begin
			pc = 32'd0;
			for (int i = 0; i < 32; i++)
				regs[i] = 32'd0;
			for (int i = 0; i < 256; i++)
				mem[i] = data_init[i];
		end else begin
			step_model();
		end
	end

endmodule

// ==== tb_mips.sv ====
/* testbench for the mips core.
   random programs per instruction class, memory models and the test summary. */
`timescale 1ns/1ps

module tb_mips import mips_pkg::*; ();

	localparam int cycles_per_test = 400;
	localparam int cycle_limit = 5 * (cycles_per_test + 10) * 11 / 10;

	logic        clk = 1'b0;
	logic        arst_n = 1'b0;
	logic [31:0] imem_addr;
	logic [31:0] instr;
	logic [31:0] dmem_addr;
	logic [31:0] dmem_wdata;
	logic        dmem_we;
	logic        dmem_re;
	logic [31:0] dmem_rdata;
	logic        err_illegal_opcode;
	logic [31:0] imem [256];
	logic [31:0] dmem [256];
	logic [31:0] data_init [256];
	int          check_errors;
	int          cycle_count = 0;
	int          passed = 0;
	int          failed = 0;
	string       test_name [5] = '{"alu", "load/store", "branch", "jump", "illegal opcode"};

	mips_core DUT (
		.clk                (clk),
		.arst_n             (arst_n),
		.imem_addr          (imem_addr),
		.instr              (instr),
		.dmem_addr          (dmem_addr),
		.dmem_wdata         (dmem_wdata),
		.dmem_we            (dmem_we),
		.dmem_re            (dmem_re),
		.dmem_rdata         (dmem_rdata),
		.err_illegal_opcode (err_illegal_opcode)
	);

	mips_checker u_checker (
		.clk                (clk),
		.arst_n             (arst_n),
		.imem               (imem),
		.data_init          (data_init),
		.imem_addr          (imem_addr),
		.dmem_addr          (dmem_addr),
		.dmem_wdata         (dmem_wdata),
		.dmem_we            (dmem_we),
		.dmem_re            (dmem_re),
		.err_illegal_opcode (err_illegal_opcode),
		.err_count          (check_errors)
	);

	always #4 clk = ~clk;

	// instr is held at zero during reset.
	assign instr = arst_n ? imem[imem_addr[9:2]] : 32'd0;
	assign dmem_rdata = dmem[dmem_addr[9:2]];

	// data memory reloads its start image while reset is held.
	always @(posedge clk) begin
		if (!arst_n) begin
			for (int i = 0; i < 256; i++)
				dmem[i] <= data_init[i];
		end else if (dmem_we) begin
			dmem[dmem_addr[9:2]] <= dmem_wdata;
		end
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count > cycle_limit) begin
			$display("timeout: the run went past %0d cycles", cycle_limit);
			$display("Test FAILED");
			$finish;
		end
	end

	function automatic logic [31:0] r_format(input logic [4:0] rs, input logic [4:0] rt,
			input logic [4:0] rd, input logic [5:0] fn);
		return {6'd0, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic logic [31:0] i_format(input logic [5:0] op, input logic [4:0] rs,
			input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [31:0] j_format(input logic [5:0] op, input logic [25:0] target);
		return {op, target};
	endfunction

	function automatic logic [4:0] pick_reg();
		return 5'($urandom_range(7));
	endfunction

	// word offset from r0 inside the data array.
	function automatic logic [15:0] store_slot();
		return {6'd0, 8'($urandom), 2'b00};
	endfunction

	function automatic logic [5:0] pick_funct();
		case ($urandom_range(4))
			0: return fn_add;
			1: return fn_sub;
			2: return fn_and;
			3: return fn_or;
			default: return fn_slt;
		endcase
	endfunction

	function automatic logic [5:0] illegal_op();
		logic [5:0] op;
		op = 6'($urandom);
		while (op inside {op_r_type, op_j, op_jal, op_beq, op_bne, op_addi, op_lw, op_sw})
			op = 6'($urandom);
		return op;
	endfunction

	task automatic build_program(input int t);
		logic [4:0] d;
		int         sel;
		int         base;
		for (int i = 0; i < 256; i++) begin
			d = pick_reg();
			sel = int'($urandom_range(5));
			case (t)
				0: begin
					// odd slots store the result of the even slot.
					if (i % 2 == 1 && imem[i - 1][31:26] == op_addi)
						imem[i] = i_format(op_sw, 5'd0, imem[i - 1][20:16], store_slot());
					else if (i % 2 == 1)
						imem[i] = i_format(op_sw, 5'd0, imem[i - 1][15:11], store_slot());
					else if (sel == 0)
						imem[i] = i_format(op_addi, pick_reg(), d, 16'($urandom));
					else
						imem[i] = r_format(pick_reg(), pick_reg(), d, pick_funct());
				end
				1: begin
					d = (i % 4 == 0) ? pick_reg() : imem[i - (i % 4)][20:16];
					case (i % 4)
						0: imem[i] = i_format(op_lw, 5'd0, d, store_slot());
						1: imem[i] = i_format(op_addi, d, d, 16'($urandom));
						2: imem[i] = r_format(d, pick_reg(), d, pick_funct());
						default: imem[i] = i_format(op_sw, 5'd0, d, store_slot());
					endcase
				end
				2: begin
					if (sel < 2)
						imem[i] = i_format(op_addi, 5'd0, d, 16'($urandom_range(3)));
					else if (sel == 2)
						imem[i] = i_format(op_beq, pick_reg(), d, 16'($urandom_range(6)));
					else if (sel == 3)
						imem[i] = i_format(op_bne, pick_reg(), d, 16'($urandom_range(6)));
					else
						imem[i] = i_format(op_sw, 5'd0, d, store_slot());
				end
				3: begin
					// main flow below 192, four subroutines of 16 words above.
					base = i - (i % 16);
					if (i == 191)
						imem[i] = j_format(op_j, 26'd0);
					else if (i < 192 && sel < 2)
						imem[i] = i_format(op_addi, pick_reg(), d, 16'($urandom));
					else if (i < 192 && sel == 2)
						imem[i] = i_format(op_sw, 5'd0, d, store_slot());
					else if (i < 192 && sel == 3)
						imem[i] = j_format(op_j, 26'(i + 2));
					else if (i < 192)
						imem[i] = j_format(op_jal, 26'(192 + 16 * $urandom_range(3)));
					else if (i == base + 15)
						imem[i] = r_format(5'd31, 5'd0, 5'd0, fn_jr);
					else if (i == base || sel == 0)
						imem[i] = i_format(op_sw, 5'd0, 5'd31, store_slot());
					else
						imem[i] = i_format(op_addi, pick_reg(), d, 16'($urandom));
				end
				default: begin
					if (sel < 2)
						imem[i] = {illegal_op(), 26'($urandom)};
					else if (sel == 2)
						imem[i] = i_format(op_addi, pick_reg(), d, 16'($urandom));
					else if (sel == 3)
						imem[i] = r_format(pick_reg(), pick_reg(), d, pick_funct());
					else
						imem[i] = i_format(op_sw, 5'd0, d, store_slot());
				end
			endcase
		end
	endtask

	initial begin
		int errors_before;
		void'($urandom(32'h5234_5dbb));
		for (int t = 0; t < 5; t++) begin
			@(negedge clk);
			arst_n = 1'b0;
			for (int i = 0; i < 256; i++)
				data_init[i] = $urandom;
			build_program(t);
			repeat (10) @(negedge clk);
			arst_n = 1'b1;
			errors_before = check_errors;
			repeat (cycles_per_test) @(negedge clk);
			#2;
			if (check_errors == errors_before) begin
				passed++;
				$display("test %0d (%s): pass", t, test_name[t]);
			end else begin
				failed++;
				$display("test %0d (%s): fail, %0d mismatches", t, test_name[t],
					check_errors - errors_before);
			end
		end
		$display("summary: %0d tests passed, %0d tests failed", passed, failed);
		if (failed == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

// ==== files.f ====
mips_pkg.sv
main_decoder.sv
alu_control.sv
alu.sv
reg_file.sv
pc_unit.sv
mips_core.sv
mips_checker.sv
tb_mips.sv

// ==== run.sh ====
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --top-module tb_mips -f files.f -o sim_tb_mips \
	&& ./obj_dir/sim_tb_mips > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "build or run error"; exit 1; }
cat sim.log
grep -q "^Test OK$" sim.log && exit 0 || exit 1
